/* Bender.yml */
package:
  name: fcpu_core

export_include_dirs:
  - hw

sources:
  - hw/fcpu_pkg.sv
  - hw/register_file.sv
  - hw/dispatch_unit.sv
  - hw/int_alu.sv
  - hw/reorder_buffer.sv
  - hw/fcpu_core.sv
  - target: simulation
    files:
      - sim/tb_fcpu_core.sv

/* build.f */
+incdir+hw
hw/fcpu_pkg.sv
hw/register_file.sv
hw/dispatch_unit.sv
hw/int_alu.sv
hw/reorder_buffer.sv
hw/fcpu_core.sv
sim/tb_fcpu_core.sv

/* hw/dispatch_unit.sv */
`include "fcpu_params.svh"

module dispatch_unit (
   input  logic                               clk,
   input  logic                               nrst,
   input  logic                               flush,
   input  logic                               instr_valid,
   input  fcpu_pkg::instr_t                   instr,
   output logic                               instr_ready,
   output logic [2:0][`FCPU_REG_ADDR_W-1:0]   rd_addrs,
   input  fcpu_pkg::rd_port_t [2:0]           rd_data,
   input  logic                               rob_full,
   input  logic [`FCPU_RSV_ID_W-1:0]          alloc_tag,
   output logic                               alloc,
   output logic                               rsv,
   output logic [`FCPU_RSV_ID_W-1:0]          rsv_tag,
   output logic                               issue_valid,
   output fcpu_pkg::issue_t                   issue
);

   import fcpu_pkg::*;

   logic use_rs1;
   logic use_rs2;
   logic src_ok;
   logic accept;

   assign rd_addrs[0] = instr.rs1;
   assign rd_addrs[1] = instr.rs2;
   assign rd_addrs[2] = instr.rd;  // destination port

   always_comb begin
      case (instr.op)
         op_li: begin
            use_rs1 = 1'b0;
            use_rs2 = 1'b0;
         end
         op_addi: begin
            use_rs1 = 1'b1;
            use_rs2 = 1'b0;
         end
         default: begin
            use_rs1 = 1'b1;
            use_rs2 = 1'b1;
         end
      endcase
   end

   // sources must hold their retired value, there is no forwarding path
   assign src_ok = (!use_rs1 || rd_data[0].filled) && (!use_rs2 || rd_data[1].filled);

   assign instr_ready = src_ok && !rob_full && !flush;
   assign accept      = instr_valid && instr_ready;

   assign alloc   = accept;
   assign rsv     = accept;
   assign rsv_tag = alloc_tag;

   always_ff @(posedge clk) begin
      if (nrst) begin
         issue_valid <= 1'b0;
      end else begin
         issue_valid <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         issue <= '{op: instr.op, tag: alloc_tag, a: rd_data[0].data,
                    b: rd_data[1].data, imm: instr.imm};
      end
   end

endmodule

/* hw/fcpu_core.sv */
`include "fcpu_params.svh"

module fcpu_core (
   input  logic              clk,
   input  logic              nrst,
   input  logic              instr_valid,
   input  fcpu_pkg::instr_t  instr,
   output logic              instr_ready,
   input  logic              branch_miss,
   input  logic              commit_hold,
   output logic              commit_valid,
   output fcpu_pkg::commit_t commit
);

   import fcpu_pkg::*;

   logic [2:0][`FCPU_REG_ADDR_W-1:0] rd_addrs;
   rd_port_t [2:0]                   rd_data;
   logic                             rsv;
   logic [`FCPU_RSV_ID_W-1:0]        rsv_tag;
   logic                             alloc;
   logic [`FCPU_RSV_ID_W-1:0]        alloc_tag;
   logic                             rob_full;
   logic                             issue_valid;
   issue_t                           issue;
   result_t                          result;
   logic                             rf_flush;

   dispatch_unit u_dispatch (
      .clk, .nrst, .flush(branch_miss), .instr_valid, .instr, .instr_ready,
      .rd_addrs, .rd_data, .rob_full, .alloc_tag, .alloc, .rsv, .rsv_tag,
      .issue_valid, .issue
   );

   register_file #(.N_RD_PORTS(3)) u_regs (
      .clk, .nrst, .flush(rf_flush), .rsv, .rsv_tag, .commit_valid, .commit,
      .rd_addrs, .rd_data
   );

   int_alu u_alu (
      .clk, .nrst, .flush(branch_miss), .issue_valid, .issue, .result
   );

   reorder_buffer u_rob (
      .clk, .nrst, .flush(branch_miss), .commit_hold, .alloc,
      .alloc_rd(rd_addrs[2]),  // destination of the accepted instruction
      .alloc_tag, .rob_full, .result, .commit_valid, .commit, .flush_out(rf_flush)
   );

endmodule

/* hw/fcpu_params.svh */
`ifndef FCPU_PARAMS_SVH
`define FCPU_PARAMS_SVH

// widths and depths shared by the back end

`define FCPU_DATA_W     32
`define FCPU_REG_ADDR_W 4   // 16 architectural registers
`define FCPU_RSV_ID_W   3   // rob tag width
`define FCPU_ROB_DEPTH  8   // must equal 2 ** FCPU_RSV_ID_W
`define FCPU_IMM_W      16

`define FCPU_N_REGS (2 ** `FCPU_REG_ADDR_W)

`endif

/* hw/fcpu_pkg.sv */
`include "fcpu_params.svh"

package fcpu_pkg;

   typedef enum logic [2:0] {
      op_add,
      op_sub,
      op_and,
      op_or,
      op_xor,
      op_addi,   // rs1 plus sign-extended imm
      op_li      // rd takes sign-extended imm
   } opcode_e;

   typedef enum logic [1:0] {
      rob_free,
      rob_busy,  // issued, result not back yet
      rob_done
   } rob_state_e;

   typedef struct packed {
      opcode_e                     op;
      logic [`FCPU_REG_ADDR_W-1:0] rd;
      logic [`FCPU_REG_ADDR_W-1:0] rs1;
      logic [`FCPU_REG_ADDR_W-1:0] rs2;
      logic [`FCPU_IMM_W-1:0]      imm;
   } instr_t;

   typedef struct packed {
      opcode_e                   op;
      logic [`FCPU_RSV_ID_W-1:0] tag;
      logic [`FCPU_DATA_W-1:0]   a;
      logic [`FCPU_DATA_W-1:0]   b;
      logic [`FCPU_IMM_W-1:0]    imm;
   } issue_t;

   typedef struct packed {
      logic                      valid;
      logic [`FCPU_RSV_ID_W-1:0] tag;
      logic [`FCPU_DATA_W-1:0]   data;
   } result_t;

   typedef struct packed {
      logic [`FCPU_REG_ADDR_W-1:0] rd;
      logic [`FCPU_RSV_ID_W-1:0]   tag;
      logic [`FCPU_DATA_W-1:0]     data;
   } commit_t;

   typedef struct packed {
      logic [`FCPU_DATA_W-1:0]   data;
      logic [`FCPU_RSV_ID_W-1:0] tag;
      logic                      filled;  // low while a tag owns the register
   } rd_port_t;

endpackage

/* hw/int_alu.sv */
`include "fcpu_params.svh"

module int_alu (
   input  logic              clk,
   input  logic              nrst,
   input  logic              flush,
   input  logic              issue_valid,
   input  fcpu_pkg::issue_t  issue,
   output fcpu_pkg::result_t result
);

   import fcpu_pkg::*;

   logic [`FCPU_DATA_W-1:0]   imm_ext;
   logic [`FCPU_DATA_W-1:0]   alu_out;
   logic                      valid_q;
   logic [`FCPU_RSV_ID_W-1:0] tag_q;
   logic [`FCPU_DATA_W-1:0]   data_q;

   assign imm_ext = {{(`FCPU_DATA_W - `FCPU_IMM_W){issue.imm[`FCPU_IMM_W-1]}}, issue.imm};

   always_comb begin
      case (issue.op)
         op_add:  alu_out = issue.a + issue.b;
         op_sub:  alu_out = issue.a - issue.b;
         op_and:  alu_out = issue.a & issue.b;
         op_or:   alu_out = issue.a | issue.b;
         op_xor:  alu_out = issue.a ^ issue.b;
         op_addi: alu_out = issue.a + imm_ext;
         op_li:   alu_out = imm_ext;
         default: alu_out = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (nrst || flush) begin  // a result in flight on a miss is dropped
         valid_q <= 1'b0;
      end else begin
         valid_q <= issue_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (issue_valid) begin
         tag_q  <= issue.tag;
         data_q <= alu_out;
      end
   end

   assign result = '{valid: valid_q, tag: tag_q, data: data_q};

endmodule

/* hw/register_file.sv */
`include "fcpu_params.svh"

module register_file #(
   parameter int N_RD_PORTS = 3
) (
   input  logic                                        clk,
   input  logic                                        nrst,
   input  logic                                        flush,
   input  logic                                        rsv,
   input  logic [`FCPU_RSV_ID_W-1:0]                   rsv_tag,
   input  logic                                        commit_valid,
   input  fcpu_pkg::commit_t                           commit,
   input  logic [N_RD_PORTS-1:0][`FCPU_REG_ADDR_W-1:0] rd_addrs,
   output fcpu_pkg::rd_port_t [N_RD_PORTS-1:0]         rd_data
);

   localparam int N_REGS   = `FCPU_N_REGS;
   localparam int DST_PORT = 2;  // last port names the destination

   logic [N_REGS-1:0][`FCPU_DATA_W-1:0]   regs_q;
   logic [N_REGS-1:0][`FCPU_RSV_ID_W-1:0] tag_q;
   logic [N_REGS-1:0][`FCPU_RSV_ID_W-1:0] tag_d;
   logic [N_REGS-1:0]                     filled_q;
   logic [N_REGS-1:0]                     filled_d;
   logic [`FCPU_REG_ADDR_W-1:0]           dst;
   logic                                  owner_match;

   assign dst = rd_addrs[DST_PORT];

   // only the newest writer of a register may mark it filled again
   assign owner_match = commit_valid && !filled_q[commit.rd]
                        && (tag_q[commit.rd] == commit.tag);

   always_comb begin
      for (int i = 0; i < N_RD_PORTS; i++) begin
         rd_data[i] = '{
            data:   regs_q[rd_addrs[i]],
            tag:    tag_q[rd_addrs[i]],
            filled: filled_q[rd_addrs[i]]
         };
      end
   end

   always_comb begin
      tag_d    = tag_q;
      filled_d = filled_q;
      if (owner_match) begin
         tag_d[commit.rd]    = '0;
         filled_d[commit.rd] = 1'b1;
      end
      if (rsv) begin  // applied last so a reservation beats a retirement
         tag_d[dst]    = rsv_tag;
         filled_d[dst] = 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (nrst) begin
         tag_q    <= '0;
         filled_q <= '1;
      end else if (flush) begin  // nothing in flight survives a miss
         tag_q    <= '0;
         filled_q <= '1;
      end else begin
         tag_q    <= tag_d;
         filled_q <= filled_d;
      end
   end

   // retirement is in program order, so the data always takes the last retired value
   always_ff @(posedge clk) begin
      if (nrst) begin
         regs_q <= '0;
      end else if (commit_valid) begin
         regs_q[commit.rd] <= commit.data;
      end
   end

   // dispatch must not reserve while the rob is being emptied
   a_no_rsv_on_flush : assert property (
      @(posedge clk) disable iff (nrst)
      rsv |-> !flush
   ) else $error("register_file: reservation in a flush cycle");

endmodule

/* hw/reorder_buffer.sv */
`include "fcpu_params.svh"

module reorder_buffer (
   input  logic                        clk,
   input  logic                        nrst,
   input  logic                        flush,
   input  logic                        commit_hold,
   input  logic                        alloc,
   input  logic [`FCPU_REG_ADDR_W-1:0] alloc_rd,
   output logic [`FCPU_RSV_ID_W-1:0]   alloc_tag,
   output logic                        rob_full,
   input  fcpu_pkg::result_t           result,
   output logic                        commit_valid,
   output fcpu_pkg::commit_t           commit,
   output logic                        flush_out
);

   import fcpu_pkg::*;

   localparam int DEPTH = `FCPU_ROB_DEPTH;

   rob_state_e                  state_q [DEPTH];
   logic [`FCPU_REG_ADDR_W-1:0] rd_q    [DEPTH];
   logic [`FCPU_DATA_W-1:0]     data_q  [DEPTH];
   logic [`FCPU_RSV_ID_W-1:0]   head_q;
   logic [`FCPU_RSV_ID_W-1:0]   tail_q;
   logic [`FCPU_RSV_ID_W:0]     count_q;
   logic                        retire;

   assign flush_out = flush;
   assign alloc_tag = tail_q;  // the tag is simply the entry index
   assign rob_full  = (count_q == DEPTH[`FCPU_RSV_ID_W:0]);

   // the head retires once its result is back and it is neither held nor squashed
   assign retire = (state_q[head_q] == rob_done) && !commit_hold && !flush;

   assign commit_valid = retire;
   assign commit       = '{rd: rd_q[head_q], tag: head_q, data: data_q[head_q]};

   always_ff @(posedge clk) begin
      if (nrst || flush) begin
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;
         for (int i = 0; i < DEPTH; i++) begin
            state_q[i] <= rob_free;
         end
      end else begin
         if (result.valid) begin
            state_q[result.tag] <= rob_done;
         end
         if (retire) begin
            state_q[head_q] <= rob_free;
            head_q          <= head_q + 1'b1;
         end
         if (alloc) begin
            state_q[tail_q] <= rob_busy;
            tail_q          <= tail_q + 1'b1;
         end
         case ({alloc, retire})
            2'b10:   count_q <= count_q + 1'b1;
            2'b01:   count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (alloc) begin
         rd_q[tail_q] <= alloc_rd;
      end
      if (result.valid) begin
         data_q[result.tag] <= result.data;
      end
   end

   // dispatch has to see rob_full before it allocates
   a_no_alloc_full : assert property (
      @(posedge clk) disable iff (nrst)
      alloc |-> !rob_full
   ) else $error("reorder_buffer: allocation while full");

   // the alu may only answer entries that are still waiting
   a_result_to_busy : assert property (
      @(posedge clk) disable iff (nrst)
      result.valid |-> (state_q[result.tag] == rob_busy)
   ) else $error("reorder_buffer: result for an entry that is not busy");

endmodule

/* sim/tb_fcpu_core.sv */
`include "fcpu_params.svh"

module tb_fcpu_core;
   timeunit 1ns;
   timeprecision 1ps;

   import fcpu_pkg::*;

   logic    clk = 1'b0;
   logic    nrst;
   logic    instr_valid;
   instr_t  instr;
   logic    instr_ready;
   logic    branch_miss;
   logic    commit_hold;
   logic    commit_valid;
   commit_t commit;

   logic [31:0]                 lcg_state = 32'h8d42;
   logic [`FCPU_DATA_W-1:0]     arch [`FCPU_N_REGS];  // retired register state
   instr_t                      pending [$];          // accepted and not yet retired
   logic                        exp_valid = 1'b0;
   logic [`FCPU_REG_ADDR_W-1:0] exp_rd = '0;
   logic [`FCPU_DATA_W-1:0]     exp_data = '0;
   logic                        model_full = 1'b0;
   logic                        src_clear = 1'b1;
   int                          value_errs = 0;
   int                          proto_errs = 0;
   int                          timeouts = 0;

   fcpu_core uut (
      .clk, .nrst, .instr_valid, .instr, .instr_ready, .branch_miss, .commit_hold,
      .commit_valid, .commit
   );

   always #5 clk = ~clk;

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;
   endfunction

   function automatic instr_t make_instr(opcode_e op, logic [3:0] rd, logic [3:0] rs1,
                                         logic [3:0] rs2, logic [15:0] imm);
      return '{op: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm};
   endfunction

   function automatic logic uses_rs1(opcode_e op);
      return op != op_li;
   endfunction

   function automatic logic uses_rs2(opcode_e op);
      return op != op_li && op != op_addi;
   endfunction

   function automatic logic [`FCPU_DATA_W-1:0] expected_value(instr_t i);
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm;
      a   = arch[i.rs1];
      b   = arch[i.rs2];
      imm = {{16{i.imm[15]}}, i.imm};
      case (i.op)
         op_add:  return a + b;
         op_sub:  return a - b;
         op_and:  return a & b;
         op_or:   return a | b;
         op_xor:  return a ^ b;
         op_addi: return a + imm;
         default: return imm;
      endcase
   endfunction

   // a source is usable only once no older instruction still writes it
   function automatic logic sources_free(instr_t i);
      foreach (pending[k]) begin
         if (uses_rs1(i.op) && pending[k].rd == i.rs1) return 1'b0;
         if (uses_rs2(i.op) && pending[k].rd == i.rs2) return 1'b0;
      end
      return 1'b1;
   endfunction

   // the reference model updates mid-cycle for the edge that follows
   always @(negedge clk) begin
      instr_t head;
      if (nrst) begin
         pending.delete();
         foreach (arch[r]) arch[r] = '0;
         exp_valid = 1'b0;
      end else begin
         model_full = (pending.size() == `FCPU_ROB_DEPTH);
         src_clear  = sources_free(instr);
         exp_valid  = 1'b0;
         if (commit_valid && pending.size() != 0) begin
            head      = pending.pop_front();
            exp_valid = 1'b1;
            exp_rd    = head.rd;
            exp_data  = expected_value(head);
            arch[head.rd] = exp_data;
         end
         if (branch_miss) begin
            pending.delete();  // everything not yet retired is squashed
         end else if (instr_valid && instr_ready) begin
            pending.push_back(instr);
         end
      end
   end

   a_reset_state : assert property (@(posedge clk) disable iff (nrst)
      $fell(nrst) |-> instr_ready && !commit_valid)
   else begin
      proto_errs++;
      $display("** Error at %0t: instr_ready = %b, commit_valid = %b, expected 1 and 0",
               $time, $sampled(instr_ready), $sampled(commit_valid));
   end

   a_commit_expected : assert property (@(posedge clk) disable iff (nrst)
      commit_valid |-> exp_valid)
   else begin
      proto_errs++;
      $display("commit_valid at %0t with no instruction outstanding", $time);
   end

   a_commit_rd : assert property (@(posedge clk) disable iff (nrst)
      commit_valid && exp_valid |-> commit.rd == exp_rd)
   else begin
      value_errs++;
      $display("** Error at %0t: commit.rd = %0d, expected %0d", $time,
               $sampled(commit.rd), $sampled(exp_rd));
   end

   a_commit_data : assert property (@(posedge clk) disable iff (nrst)
      commit_valid && exp_valid |-> commit.data == exp_data)
   else begin
      value_errs++;
      $display("** Error at %0t: commit.data = %h, expected %h", $time,
               $sampled(commit.data), $sampled(exp_data));
   end

   a_no_early_accept : assert property (@(posedge clk) disable iff (nrst)
      instr_valid && instr_ready |-> src_clear)
   else begin
      proto_errs++;
      $display("instruction accepted at %0t while a source was still in flight", $time);
   end

   a_full_stalls : assert property (@(posedge clk) disable iff (nrst)
      model_full |-> !instr_ready)
   else begin
      proto_errs++;
      $display("instr_ready high at %0t with eight instructions outstanding", $time);
   end

   a_hold_blocks : assert property (@(posedge clk) disable iff (nrst)
      commit_hold |-> !commit_valid)
   else begin
      proto_errs++;
      $display("retirement at %0t while commit_hold was high", $time);
   end

   a_miss_blocks : assert property (@(posedge clk) disable iff (nrst)
      branch_miss |-> !commit_valid && !(instr_valid && instr_ready))
   else begin
      proto_errs++;
      $display("retirement or acceptance at %0t in a branch_miss cycle", $time);
   end

   task automatic send(input instr_t i);
      int waited;
      waited      = 0;
      instr_valid = 1'b1;
      instr       = i;
      @(negedge clk);
      while (!instr_ready && waited < 100) begin
         waited++;
         @(negedge clk);
      end
      if (!instr_ready) begin
         timeouts++;
         $display("timeout at %0t, instruction for r%0d was never accepted", $time, i.rd);
      end
      @(posedge clk);
      #1;
      instr_valid = 1'b0;
   endtask

   task automatic drain();
      int waited;
      waited = 0;
      do begin
         @(posedge clk);
         waited++;
      end while (pending.size() != 0 && waited < 200);
      if (pending.size() != 0) begin
         timeouts++;
         $display("timeout at %0t, %0d instructions never retired", $time, pending.size());
      end
      #1;
   endtask

   task automatic pulse_miss();
      branch_miss = 1'b1;
      @(posedge clk);
      #1;
      branch_miss = 1'b0;
   endtask

   initial begin
      logic [31:0] rnd;
      logic [3:0]  prev;
      instr_t      held;
      nrst        = 1'b1;
      instr_valid = 1'b0;
      instr       = '0;
      branch_miss = 1'b0;
      commit_hold = 1'b0;
      repeat (8) @(posedge clk);
      #1;
      nrst = 1'b0;

      for (int r = 0; r < 16; r++) begin
         send(make_instr(op_add, 4'(r), 4'd0, 4'd0, 16'd0));
      end
      drain();

      // seed the low half, then mix every opcode into the high half
      for (int r = 0; r < 8; r++) begin
         rnd = next_rand();
         send(make_instr(op_li, 4'(r), 4'd0, 4'd0, rnd[23:8]));
      end
      for (int n = 0; n < 40; n++) begin
         rnd = next_rand();
         send(make_instr(opcode_e'(3'((rnd >> 8) % 7)), {1'b1, rnd[26:24]},
                         {1'b0, rnd[29:27]}, {1'b0, rnd[4:2]}, rnd[23:8]));
      end
      drain();

      prev = 4'd1;
      rnd  = next_rand();
      send(make_instr(op_li, prev, 4'd0, 4'd0, rnd[23:8]));
      for (int n = 0; n < 12; n++) begin
         rnd = next_rand();
         send(make_instr(opcode_e'(3'((rnd >> 8) % 6)), 4'(n % 7 + 2), prev, prev,
                         rnd[23:8]));
         prev = 4'(n % 7 + 2);
      end
      drain();

      send(make_instr(op_li, 4'd5, 4'd0, 4'd0, 16'h1234));
      send(make_instr(op_li, 4'd5, 4'd0, 4'd0, 16'h8001));
      send(make_instr(op_add, 4'd6, 4'd5, 4'd5, 16'd0));
      drain();

      commit_hold = 1'b1;
      for (int n = 0; n < 8; n++) begin
         rnd = next_rand();
         send(make_instr(op_li, 4'(n + 8), 4'd0, 4'd0, rnd[23:8]));
      end
      held        = make_instr(op_li, 4'd0, 4'd0, 4'd0, 16'h00a5);
      instr_valid = 1'b1;  // offered while the rob is full
      instr       = held;
      repeat (4) @(posedge clk);
      #1;
      commit_hold = 1'b0;
      send(held);
      drain();

      commit_hold = 1'b1;
      for (int n = 0; n < 4; n++) begin
         send(make_instr(op_li, 4'(n + 9), 4'd0, 4'd0, 16'(16'h7700 + n)));
      end
      held        = make_instr(op_li, 4'd15, 4'd0, 4'd0, 16'h5a5a);
      instr_valid = 1'b1;  // offered in the miss cycle and taken only after it
      instr       = held;
      pulse_miss();
      commit_hold = 1'b0;
      send(held);
      send(make_instr(op_add, 4'd13, 4'd9, 4'd10, 16'd0));
      send(make_instr(op_xor, 4'd14, 4'd11, 4'd12, 16'd0));
      drain();

      for (int n = 1; n < 4; n++) begin
         send(make_instr(op_li, 4'(n), 4'd0, 4'd0, 16'(16'hc000 + n)));
      end
      pulse_miss();  // all three are still in flight
      send(make_instr(op_or, 4'd4, 4'd1, 4'd2, 16'd0));
      send(make_instr(op_addi, 4'd7, 4'd3, 4'd0, 16'hfff0));
      drain();

      $display("errors: %0d value, %0d protocol, %0d timeout", value_errs, proto_errs,
               timeouts);
      if (value_errs + proto_errs + timeouts == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule
